// File: project.f
+incdir+common
common/mem_pkg.sv
mem/data_mem.sv
hdl/lsu_ctrl.sv
hdl/mem_arbiter.sv
hdl/mem_subsys_top.sv
dv/mem_subsys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module mem_subsys_tb \
  -f project.f \
  -o mem_subsys_sim

sim_out=$(./obj_dir/mem_subsys_sim)
echo "$sim_out"

if grep -qx "Finished with no errors" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

// File: dv/mem_subsys_tb.sv
// Memory subsystem testbench

`timescale 1ns/1ps

`include "mem_consts.svh"

module mem_subsys_tb;

  localparam int RAND_OPS = 72;  // 32 preload stores and 40 mixed accesses
  localparam int HS_LIMIT = 32;  // cycles allowed per handshake phase

  typedef struct packed {
    logic                       is_fetch;
    mem_pkg::mem_op_e           op;
    logic [`MEM_ADDR_WIDTH-1:0] addr;
    logic [`XLEN-1:0]           wdata;
    logic [`XLEN-1:0]           exp_rdata;
    logic                       exp_err;
  } vec_t;

  logic                       clk;
  logic                       rst_n;
  logic                       fetch_req;
  logic [`MEM_ADDR_WIDTH-1:0] fetch_addr;
  logic                       fetch_ack;
  logic [`XLEN-1:0]           fetch_rdata;
  logic                       fetch_err;
  logic                       data_req;
  mem_pkg::mem_op_e           data_op;
  logic [`MEM_ADDR_WIDTH-1:0] data_addr;
  logic [`XLEN-1:0]           data_wdata;
  logic                       data_ack;
  logic [`XLEN-1:0]           data_rdata;
  logic                       data_err;

  vec_t                       vec_q[$];
  logic [`MEM_ADDR_WIDTH-1:0] fetch_addr_q[$];
  mem_pkg::mem_op_e           data_op_q[$];
  logic [`MEM_ADDR_WIDTH-1:0] data_addr_q[$];
  logic [`XLEN-1:0]           data_wdata_q[$];
  logic [7:0]                 ref_mem [0:`MEM_SIZE_BYTES-1];  // byte model of the memory
  integer                     seed;
  logic [31:0]                r;
  mem_pkg::mem_op_e           op;
  logic [1:0]                 off;
  int                         k;
  int                         value_errs;
  int                         proto_errs;
  int                         mon_errs = 0;
  int                         grant_cnt = 0;
  int                         cycle_cnt;
  int                         cycle_limit;
  bit                         fetch_busy;
  bit                         data_busy;
  bit                         both_phase;
  bit                         first_seen = 1'b0;
  bit                         first_data = 1'b0;
  bit                         prev_fetch_ack = 1'b0;
  bit                         prev_data_ack = 1'b0;

  mem_subsys_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic add_vec(input logic f, input mem_pkg::mem_op_e o, input logic [11:0] a,
                         input logic [31:0] wd, input logic [31:0] rd, input logic e);
    vec_q.push_back(vec_t'{f, o, a, wd, rd, e});
  endtask

  task automatic check_rdata(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t %s: rdata 0x%08h, expected 0x%08h", $time, what, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t %s: err %b, expected %b", $time, what, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_result(input string what, input logic [`XLEN-1:0] rdata, input logic err,
                              input logic [`XLEN-1:0] exp_rdata, input logic exp_err);
    check_err(err, exp_err, what);
    if (!exp_err) check_rdata(rdata, exp_rdata, what);  // data is don't-care on error
  endtask

  // sample an ack at falling edges until it reaches the wanted level
  task automatic wait_ack(input bit on_fetch, input bit level, output bit ok);
    int waited;
    waited = 0;
    @(negedge clk);
    while (((on_fetch ? fetch_ack : data_ack) !== level) && (waited < HS_LIMIT)) begin
      @(negedge clk);
      waited++;
    end
    ok = ((on_fetch ? fetch_ack : data_ack) === level);
    if (!ok) begin
      $display("ERROR: %s port handshake stuck waiting for ack %s at %0t",
               on_fetch ? "fetch" : "data", level ? "high" : "low", $time);
      proto_errs++;
    end
  endtask

  task automatic fetch_access(input logic [`MEM_ADDR_WIDTH-1:0] addr,
                              output logic [`XLEN-1:0] rdata, output logic err, output bit ok);
    @(posedge clk);
    fetch_busy = 1'b1;
    fetch_req  <= 1'b1;
    fetch_addr <= addr;
    wait_ack(1'b1, 1'b1, ok);
    rdata = fetch_rdata;  // held while ack is high
    err   = fetch_err;
    @(posedge clk);
    fetch_req <= 1'b0;
    if (ok) wait_ack(1'b1, 1'b0, ok);
    fetch_busy = 1'b0;
  endtask

  task automatic data_access(input mem_pkg::mem_op_e o, input logic [`MEM_ADDR_WIDTH-1:0] addr,
                             input logic [`XLEN-1:0] wdata, output logic [`XLEN-1:0] rdata,
                             output logic err, output bit ok);
    @(posedge clk);
    data_busy = 1'b1;
    data_req   <= 1'b1;
    data_op    <= o;
    data_addr  <= addr;
    data_wdata <= wdata;
    wait_ack(1'b0, 1'b1, ok);
    rdata = data_rdata;
    err   = data_err;
    @(posedge clk);
    data_req <= 1'b0;
    if (ok) wait_ack(1'b0, 1'b0, ok);
    data_busy = 1'b0;
  endtask

  // byte model store with upper lanes picked by concatenation
  task automatic model_store(input mem_pkg::mem_op_e o, input logic [`MEM_ADDR_WIDTH-1:0] a,
                             input logic [`XLEN-1:0] wdata);
    ref_mem[a] = wdata[7:0];
    if (o != mem_pkg::SB) ref_mem[{a[`MEM_ADDR_WIDTH-1:1], 1'b1}] = wdata[15:8];
    if (o == mem_pkg::SW) begin
      ref_mem[{a[`MEM_ADDR_WIDTH-1:2], 2'b10}] = wdata[23:16];
      ref_mem[{a[`MEM_ADDR_WIDTH-1:2], 2'b11}] = wdata[31:24];
    end
  endtask

  function automatic logic [`XLEN-1:0] model_load(input mem_pkg::mem_op_e o,
                                                  input logic [`MEM_ADDR_WIDTH-1:0] a);
    logic [7:0]  b;
    logic [15:0] h;
    b = ref_mem[a];
    h = {ref_mem[{a[`MEM_ADDR_WIDTH-1:1], 1'b1}], b};
    case (o)
      mem_pkg::LB:  return {{24{b[7]}}, b};
      mem_pkg::LBU: return {24'h0, b};
      mem_pkg::LH:  return {{16{h[15]}}, h};
      mem_pkg::LHU: return {16'h0, h};
      mem_pkg::LW:  return {ref_mem[{a[`MEM_ADDR_WIDTH-1:2], 2'b11}],
                            ref_mem[{a[`MEM_ADDR_WIDTH-1:2], 2'b10}], h};
      default:      return '0;  // stores answer with zero
    endcase
  endfunction

  task automatic data_check(input mem_pkg::mem_op_e o, input logic [`MEM_ADDR_WIDTH-1:0] addr,
                            input logic [`XLEN-1:0] wdata);
    logic [`XLEN-1:0] rdata;
    logic [`XLEN-1:0] exp_rdata;
    logic             err;
    bit               ok;
    exp_rdata = model_load(o, addr);
    data_access(o, addr, wdata, rdata, err, ok);
    if (ok) begin
      check_result($sformatf("data %s 0x%03h", o.name(), addr), rdata, err, exp_rdata, 1'b0);
    end
    if (ok && !err && (o inside {mem_pkg::SB, mem_pkg::SH, mem_pkg::SW})) begin
      model_store(o, addr, wdata);
    end
  endtask

  task automatic fetch_check(input logic [`MEM_ADDR_WIDTH-1:0] addr);
    logic [`XLEN-1:0] rdata;
    logic             err;
    bit               ok;
    fetch_access(addr, rdata, err, ok);
    if (ok) begin
      check_result($sformatf("fetch 0x%03h", addr), rdata, err,
                   model_load(mem_pkg::LW, addr), 1'b0);
    end
  endtask

  task automatic apply_vec(input vec_t v, input int idx);
    logic [`XLEN-1:0] rdata;
    logic             err;
    bit               ok;
    if (v.is_fetch) fetch_access(v.addr, rdata, err, ok);
    else data_access(v.op, v.addr, v.wdata, rdata, err, ok);
    if (ok) check_result($sformatf("table entry %0d", idx), rdata, err, v.exp_rdata, v.exp_err);
  endtask

  // acks only on a busy port and never both at once
  always @(negedge clk) begin
    if (rst_n) begin
      if ((fetch_ack && !fetch_busy) || (data_ack && !data_busy) || (fetch_ack && data_ack)) begin
        $display("ERROR: ack raised on a port without a pending request at %0t", $time);
        mon_errs++;
      end
      if (both_phase && ((fetch_ack && !prev_fetch_ack) || (data_ack && !prev_data_ack))) begin
        if (!first_seen) begin
          first_seen = 1'b1;  // winner of this round
          first_data = data_ack;
        end
        grant_cnt++;
      end
      prev_fetch_ack = fetch_ack;
      prev_data_ack  = data_ack;
    end
  end

  initial begin
    cycle_cnt = 0;
    @(posedge clk);
    cycle_limit = (vec_q.size() + RAND_OPS) * 16 + 100;
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("ERROR: run did not finish within %0d cycles", cycle_limit);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    seed       = 32'h4dc1_b1f6;
    value_errs = 0;
    proto_errs = 0;
    fetch_busy = 1'b0;
    data_busy  = 1'b0;
    both_phase = 1'b0;
    rst_n      = 1'b0;
    fetch_req  = 1'b0;
    fetch_addr = '0;
    data_req   = 1'b0;
    data_op    = mem_pkg::LW;
    data_addr  = '0;
    data_wdata = '0;
    // word store and load back
    add_vec(1'b0, mem_pkg::SW,  12'h100, 32'hdead_beef, 32'h0000_0000, 1'b0);
    add_vec(1'b0, mem_pkg::LW,  12'h100, 32'h0,         32'hdead_beef, 1'b0);
    // lane merge then signed and unsigned reads of the same bytes
    add_vec(1'b0, mem_pkg::SW,  12'h104, 32'h0,         32'h0000_0000, 1'b0);
    add_vec(1'b0, mem_pkg::SB,  12'h104, 32'h0000_00f0, 32'h0000_0000, 1'b0);
    add_vec(1'b0, mem_pkg::SB,  12'h105, 32'h0000_007a, 32'h0000_0000, 1'b0);
    add_vec(1'b0, mem_pkg::SH,  12'h106, 32'h0000_85c3, 32'h0000_0000, 1'b0);
    add_vec(1'b0, mem_pkg::LW,  12'h104, 32'h0,         32'h85c3_7af0, 1'b0);
    add_vec(1'b0, mem_pkg::LB,  12'h104, 32'h0,         32'hffff_fff0, 1'b0);
    add_vec(1'b0, mem_pkg::LBU, 12'h104, 32'h0,         32'h0000_00f0, 1'b0);
    add_vec(1'b0, mem_pkg::LB,  12'h105, 32'h0,         32'h0000_007a, 1'b0);
    add_vec(1'b0, mem_pkg::LB,  12'h107, 32'h0,         32'hffff_ff85, 1'b0);
    add_vec(1'b0, mem_pkg::LBU, 12'h106, 32'h0,         32'h0000_00c3, 1'b0);
    add_vec(1'b0, mem_pkg::LH,  12'h104, 32'h0,         32'h0000_7af0, 1'b0);
    add_vec(1'b0, mem_pkg::LH,  12'h106, 32'h0,         32'hffff_85c3, 1'b0);
    add_vec(1'b0, mem_pkg::LHU, 12'h106, 32'h0,         32'h0000_85c3, 1'b0);
    // misaligned accesses leave the stored word alone
    add_vec(1'b0, mem_pkg::SW,  12'h108, 32'h1234_5678, 32'h0000_0000, 1'b0);
    add_vec(1'b0, mem_pkg::LH,  12'h109, 32'h0,         32'h0000_0000, 1'b1);
    add_vec(1'b0, mem_pkg::LW,  12'h10a, 32'h0,         32'h0000_0000, 1'b1);
    add_vec(1'b0, mem_pkg::SH,  12'h10b, 32'h0000_aaaa, 32'h0000_0000, 1'b1);
    add_vec(1'b0, mem_pkg::SW,  12'h10a, 32'hffff_ffff, 32'h0000_0000, 1'b1);
    add_vec(1'b0, mem_pkg::LW,  12'h108, 32'h0,         32'h1234_5678, 1'b0);
    add_vec(1'b0, mem_pkg::LHU, 12'h10a, 32'h0,         32'h0000_1234, 1'b0);
    // fetches of data written above
    add_vec(1'b1, mem_pkg::LW,  12'h100, 32'h0,         32'hdead_beef, 1'b0);
    add_vec(1'b1, mem_pkg::LW,  12'h104, 32'h0,         32'h85c3_7af0, 1'b0);
    add_vec(1'b1, mem_pkg::LW,  12'h102, 32'h0,         32'h0000_0000, 1'b1);
    add_vec(1'b1, mem_pkg::LW,  12'h108, 32'h0,         32'h1234_5678, 1'b0);
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if ((fetch_ack !== 1'b0) || (data_ack !== 1'b0)) begin
      $display("ERROR: an ack is not low right after reset");
      proto_errs++;
    end
    foreach (vec_q[i]) apply_vec(vec_q[i], i);
    for (k = 0; k < 32; k++) begin  // fill fetch region 0x800 and data region 0x900
      r = $random(seed);
      data_check(mem_pkg::SW, {3'b100, k[4], 2'b00, k[3:0], 2'b00}, r);
    end
    for (k = 0; k < 20; k++) begin
      r  = $random(seed);
      op = mem_pkg::mem_op_e'(r[6:4]);
      case (op)
        mem_pkg::LB, mem_pkg::LBU, mem_pkg::SB: off = r[8:7];
        mem_pkg::LH, mem_pkg::LHU, mem_pkg::SH: off = {r[8], 1'b0};
        default:                                off = 2'b00;
      endcase
      fetch_addr_q.push_back({4'h8, 2'b00, r[3:0], 2'b00});
      data_op_q.push_back(op);
      data_addr_q.push_back({4'h9, 2'b00, r[12:9], off});
      data_wdata_q.push_back($random(seed));
    end
    both_phase = 1'b1;
    // even rounds start both ports together, odd rounds let one port go first
    for (k = 0; k < 20; k++) begin
      first_seen = 1'b0;
      fork
        begin
          if (k % 4 == 1) @(posedge clk);  // data port served alone first
          fetch_check(fetch_addr_q.pop_front());
        end
        begin
          if (k % 4 == 3) @(posedge clk);  // fetch port served alone first
          data_check(data_op_q.pop_front(), data_addr_q.pop_front(),
                     data_wdata_q.pop_front());
        end
      join
      // a tie goes to the port not served last, fetch after data and data after fetch
      if ((k % 2 == 0) && (first_data !== (k % 4 == 2))) begin
        $display("ERROR: round %0d tie was granted to the port served last at %0t", k, $time);
        mon_errs++;
      end
    end
    both_phase = 1'b0;
    if (grant_cnt != 40) begin
      $display("ERROR: saw %0d grants under contention instead of 40", grant_cnt);
      proto_errs++;
    end
    $display("errors: value %0d, handshake %0d, monitor %0d", value_errs, proto_errs, mon_errs);
    if ((value_errs + proto_errs + mon_errs) == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: hdl/mem_subsys_top.sv
// Shared memory subsystem top

`timescale 1ns/1ps

`include "mem_consts.svh"

module mem_subsys_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       fetch_req,
  input  logic [`MEM_ADDR_WIDTH-1:0] fetch_addr,
  output logic                       fetch_ack,
  output logic [`XLEN-1:0]           fetch_rdata,
  output logic                       fetch_err,
  input  logic                       data_req,
  input  mem_pkg::mem_op_e           data_op,
  input  logic [`MEM_ADDR_WIDTH-1:0] data_addr,
  input  logic [`XLEN-1:0]           data_wdata,
  output logic                       data_ack,
  output logic [`XLEN-1:0]           data_rdata,
  output logic                       data_err
);

  // arbiter to controller
  logic                       acc_req;
  mem_pkg::mem_op_e           acc_op;
  logic [`MEM_ADDR_WIDTH-1:0] acc_addr;
  logic [`XLEN-1:0]           acc_wdata;
  logic                       acc_ack;
  logic [`XLEN-1:0]           acc_rdata;
  logic                       acc_err;

  // controller to memory
  logic                       mem_we;
  mem_pkg::mem_width_e        mem_width;
  logic                       mem_sign_ext;
  logic [`MEM_ADDR_WIDTH-1:0] mem_addr;
  logic [`XLEN-1:0]           mem_wdata;
  logic [`XLEN-1:0]           mem_rdata;
  logic                       mem_align_err;

  mem_arbiter i_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_ack   (fetch_ack),
    .fetch_rdata (fetch_rdata),
    .fetch_err   (fetch_err),
    .data_req    (data_req),
    .data_op     (data_op),
    .data_addr   (data_addr),
    .data_wdata  (data_wdata),
    .data_ack    (data_ack),
    .data_rdata  (data_rdata),
    .data_err    (data_err),
    .acc_req     (acc_req),
    .acc_op      (acc_op),
    .acc_addr    (acc_addr),
    .acc_wdata   (acc_wdata),
    .acc_ack     (acc_ack),
    .acc_rdata   (acc_rdata),
    .acc_err     (acc_err)
  );

  lsu_ctrl i_lsu (
    .clk           (clk),
    .rst_n         (rst_n),
    .acc_req       (acc_req),
    .acc_op        (acc_op),
    .acc_addr      (acc_addr),
    .acc_wdata     (acc_wdata),
    .acc_ack       (acc_ack),
    .acc_rdata     (acc_rdata),
    .acc_err       (acc_err),
    .mem_we        (mem_we),
    .mem_width     (mem_width),
    .mem_sign_ext  (mem_sign_ext),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_rdata     (mem_rdata),
    .mem_align_err (mem_align_err)
  );

  data_mem i_mem (
    .clk           (clk),
    .mem_we        (mem_we),
    .mem_width     (mem_width),
    .mem_sign_ext  (mem_sign_ext),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_rdata     (mem_rdata),
    .mem_align_err (mem_align_err)
  );

endmodule

// File: hdl/mem_arbiter.sv
// Round-robin fetch/data arbiter

`timescale 1ns/1ps

`include "mem_consts.svh"

module mem_arbiter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       fetch_req,
  input  logic [`MEM_ADDR_WIDTH-1:0] fetch_addr,
  output logic                       fetch_ack,
  output logic [`XLEN-1:0]           fetch_rdata,
  output logic                       fetch_err,
  input  logic                       data_req,
  input  mem_pkg::mem_op_e           data_op,
  input  logic [`MEM_ADDR_WIDTH-1:0] data_addr,
  input  logic [`XLEN-1:0]           data_wdata,
  output logic                       data_ack,
  output logic [`XLEN-1:0]           data_rdata,
  output logic                       data_err,
  output logic                       acc_req,
  output mem_pkg::mem_op_e           acc_op,
  output logic [`MEM_ADDR_WIDTH-1:0] acc_addr,
  output logic [`XLEN-1:0]           acc_wdata,
  input  logic                       acc_ack,
  input  logic [`XLEN-1:0]           acc_rdata,
  input  logic                       acc_err
);

  mem_pkg::arb_state_e state;
  logic                grant_data;  // current grant, also last served
  logic                pick_data;
  logic                any_req;
  logic                port_req;

  assign any_req   = fetch_req | data_req;
  assign pick_data = data_req & (~fetch_req | ~grant_data);  // favor the port not served last
  assign port_req  = grant_data ? data_req : fetch_req;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= mem_pkg::ARB_IDLE;
      grant_data <= 1'b0;  // data port wins first
      acc_req    <= 1'b0;
      fetch_ack  <= 1'b0;
      data_ack   <= 1'b0;
    end else begin
      case (state)
        mem_pkg::ARB_IDLE: begin
          if (any_req) begin
            grant_data <= pick_data;
            acc_req    <= 1'b1;
            state      <= mem_pkg::ARB_ISSUE;
          end
        end
        mem_pkg::ARB_ISSUE: begin
          if (acc_ack) begin
            fetch_ack <= ~grant_data;
            data_ack  <= grant_data;
            state     <= mem_pkg::ARB_RETURN;
          end
        end
        mem_pkg::ARB_RETURN: begin
          if (!port_req) begin
            acc_req <= 1'b0;
            state   <= mem_pkg::ARB_RELEASE;
          end
        end
        mem_pkg::ARB_RELEASE: begin
          if (!acc_ack) begin
            fetch_ack <= 1'b0;
            data_ack  <= 1'b0;
            state     <= mem_pkg::ARB_IDLE;
          end
        end
        default: state <= mem_pkg::ARB_IDLE;
      endcase
    end
  end

  // winner payload, held for the whole transfer
  always_ff @(posedge clk) begin
    if ((state == mem_pkg::ARB_IDLE) && any_req) begin
      acc_op    <= pick_data ? data_op : mem_pkg::LW;  // fetch is a word load
      acc_addr  <= pick_data ? data_addr : fetch_addr;
      acc_wdata <= pick_data ? data_wdata : '0;
    end
  end

  // result goes to the granted port only
  always_ff @(posedge clk) begin
    if ((state == mem_pkg::ARB_ISSUE) && acc_ack) begin
      if (grant_data) begin
        data_rdata <= acc_rdata;
        data_err   <= acc_err;
      end else begin
        fetch_rdata <= acc_rdata;
        fetch_err   <= acc_err;
      end
    end
  end

endmodule

// File: hdl/lsu_ctrl.sv
// Load/store access controller

`timescale 1ns/1ps

`include "mem_consts.svh"

module lsu_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       acc_req,
  input  mem_pkg::mem_op_e           acc_op,
  input  logic [`MEM_ADDR_WIDTH-1:0] acc_addr,
  input  logic [`XLEN-1:0]           acc_wdata,
  output logic                       acc_ack,
  output logic [`XLEN-1:0]           acc_rdata,
  output logic                       acc_err,
  output logic                       mem_we,
  output mem_pkg::mem_width_e        mem_width,
  output logic                       mem_sign_ext,
  output logic [`MEM_ADDR_WIDTH-1:0] mem_addr,
  output logic [`XLEN-1:0]           mem_wdata,
  input  logic [`XLEN-1:0]           mem_rdata,
  input  logic                       mem_align_err
);

  mem_pkg::lsu_state_e state;
  mem_pkg::lsu_state_e state_nxt;
  logic                is_store;

  // opcode decode
  always_comb begin
    mem_width    = mem_pkg::WORD;
    mem_sign_ext = 1'b0;
    is_store     = 1'b0;
    case (acc_op)
      mem_pkg::LB: begin
        mem_width    = mem_pkg::BYTE;
        mem_sign_ext = 1'b1;
      end
      mem_pkg::LH: begin
        mem_width    = mem_pkg::HALF;
        mem_sign_ext = 1'b1;
      end
      mem_pkg::LW:  mem_width = mem_pkg::WORD;
      mem_pkg::LBU: mem_width = mem_pkg::BYTE;  // zero extend
      mem_pkg::LHU: mem_width = mem_pkg::HALF;
      mem_pkg::SB: begin
        mem_width = mem_pkg::BYTE;
        is_store  = 1'b1;
      end
      mem_pkg::SH: begin
        mem_width = mem_pkg::HALF;
        is_store  = 1'b1;
      end
      mem_pkg::SW: begin
        mem_width = mem_pkg::WORD;
        is_store  = 1'b1;
      end
      default: mem_width = mem_pkg::WORD;
    endcase
  end

  // address and data come straight from the latched channel
  assign mem_addr  = acc_addr;
  assign mem_wdata = acc_wdata;
  assign mem_we    = (state == mem_pkg::LSU_ACCESS) && is_store;  // one-cycle write strobe
  assign acc_ack   = (state == mem_pkg::LSU_RESPOND);

  always_comb begin
    state_nxt = state;
    case (state)
      mem_pkg::LSU_IDLE: begin
        if (acc_req) begin
          state_nxt = mem_pkg::LSU_ACCESS;
        end
      end
      mem_pkg::LSU_ACCESS: state_nxt = mem_pkg::LSU_RESPOND;
      mem_pkg::LSU_RESPOND: begin
        if (!acc_req) begin
          state_nxt = mem_pkg::LSU_IDLE;  // ack falls here
        end
      end
      default: state_nxt = mem_pkg::LSU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= mem_pkg::LSU_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // result captured on the edge leaving ACCESS
  always_ff @(posedge clk) begin
    if (state == mem_pkg::LSU_ACCESS) begin
      acc_rdata <= is_store ? '0 : mem_rdata;  // stores return zero
      acc_err   <= mem_align_err;
    end
  end

endmodule

// File: mem/data_mem.sv
// Byte-addressed data memory

`timescale 1ns/1ps

`include "mem_consts.svh"

module data_mem (
  input  logic                       clk,
  input  logic                       mem_we,
  input  mem_pkg::mem_width_e        mem_width,
  input  logic                       mem_sign_ext,
  input  logic [`MEM_ADDR_WIDTH-1:0] mem_addr,
  input  logic [`XLEN-1:0]           mem_wdata,
  output logic [`XLEN-1:0]           mem_rdata,
  output logic                       mem_align_err
);

  logic [`XLEN-1:0]           mem_array [0:`MEM_SIZE_BYTES/4-1];
  logic [`MEM_ADDR_WIDTH-3:0] word_idx;
  logic [3:0][7:0]            rd_lanes;
  logic [3:0][7:0]            wr_lanes;
  logic [7:0]                 rd_byte;
  logic [15:0]                rd_half;

  assign word_idx = mem_addr[`MEM_ADDR_WIDTH-1:2];  // byte offset dropped
  assign rd_lanes = mem_array[word_idx];

  // lane picks for the narrow reads
  assign rd_byte = rd_lanes[mem_addr[1:0]];
  assign rd_half = {rd_lanes[{mem_addr[1], 1'b1}], rd_lanes[{mem_addr[1], 1'b0}]};

  // read extraction and alignment check
  always_comb begin
    mem_rdata     = '0;
    mem_align_err = 1'b0;
    case (mem_width)
      mem_pkg::BYTE: begin
        mem_rdata = {{24{mem_sign_ext & rd_byte[7]}}, rd_byte};
      end
      mem_pkg::HALF: begin
        mem_align_err = mem_addr[0];  // odd address
        mem_rdata     = {{16{mem_sign_ext & rd_half[15]}}, rd_half};
      end
      mem_pkg::WORD: begin
        mem_align_err = (mem_addr[1:0] != 2'b00);
        mem_rdata     = rd_lanes;
      end
      default: begin
        mem_rdata     = '0;  // unused encoding
        mem_align_err = 1'b0;
      end
    endcase
  end

  // merge new lanes into the old word
  always_comb begin
    wr_lanes = rd_lanes;
    case (mem_width)
      mem_pkg::BYTE: begin
        wr_lanes[mem_addr[1:0]] = mem_wdata[7:0];
      end
      mem_pkg::HALF: begin
        wr_lanes[{mem_addr[1], 1'b1}] = mem_wdata[15:8];
        wr_lanes[{mem_addr[1], 1'b0}] = mem_wdata[7:0];
      end
      mem_pkg::WORD: begin
        wr_lanes = mem_wdata;
      end
      default: begin
        wr_lanes = rd_lanes;  // keep old word
      end
    endcase
  end

  // a misaligned store leaves the array untouched
  always_ff @(posedge clk) begin
    if (mem_we && !mem_align_err) begin
      mem_array[word_idx] <= wr_lanes;
    end
  end

endmodule

// File: common/mem_pkg.sv
// Memory subsystem types

package mem_pkg;

  // data-port load/store opcode
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LH  = 3'd1,
    LW  = 3'd2,
    LBU = 3'd3,
    LHU = 3'd4,
    SB  = 3'd5,
    SH  = 3'd6,
    SW  = 3'd7
  } mem_op_e;

  // access width seen by the memory array
  typedef enum logic [1:0] {
    BYTE = 2'd0,
    HALF = 2'd1,
    WORD = 2'd2
  } mem_width_e;

  // access controller FSM
  typedef enum logic [1:0] {
    LSU_IDLE    = 2'd0,
    LSU_ACCESS  = 2'd1,
    LSU_RESPOND = 2'd2
  } lsu_state_e;

  // arbiter FSM
  typedef enum logic [1:0] {
    ARB_IDLE    = 2'd0,
    ARB_ISSUE   = 2'd1,
    ARB_RETURN  = 2'd2,
    ARB_RELEASE = 2'd3
  } arb_state_e;

endpackage

// File: common/mem_consts.svh
// Memory subsystem constants

`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// total memory in bytes
`define MEM_SIZE_BYTES 4096

// byte address width, log2 of the size
`define MEM_ADDR_WIDTH 12

// data path width
`define XLEN 32

`endif
